//--- hdl/pcWordPkg.sv
`default_nettype none

package pcWordPkg;

  //////////////////////////////////////////////////
  // word layout seen by the PC
  //////////////////////////////////////////////////

  // every upward word is an 8-bit code over a 24-bit payload
  localparam int unsigned CODE_WIDTH = 8;
  localparam int unsigned PAYLOAD_WIDTH = 24;

  // BD leaves own codes 0..12, the FPGA owns the two above
  localparam logic [CODE_WIDTH-1:0] CODE_SPIKE = 8'd14;
  localparam logic [CODE_WIDTH-1:0] CODE_HEARTBEAT = 8'd15;

  // second word of a spike event
  // filter index on top, then the three state bits that did not fit
  typedef struct packed {
    logic [20:0] filtIdx;
    logic [2:0]  stateHi;
  } spikeHi;

  // payload view
  // raw for BD chunks, heartbeat halves and the first spike word
  // hi only for the second spike word
  typedef union packed {
    logic [PAYLOAD_WIDTH-1:0] raw;
    spikeHi                   hi;
  } pcPayload;

  // full 32-bit word, code in the top byte
  typedef struct packed {
    logic [CODE_WIDTH-1:0] code;
    pcPayload              payload;
  } pcWord;

  // one stream beat, valid on top
  typedef struct packed {
    logic  valid;
    pcWord word;
  } pcStream;

endpackage

`default_nettype wire

//--- hdl/eventPkg.sv
`default_nettype none

package eventPkg;

  //////////////////////////////////////////////////
  // events arriving from upstream
  //////////////////////////////////////////////////

  // packet from the chip's output funnel
  // leaf selects the funnel branch, data is sent in 24-bit chunks
  typedef struct packed {
    logic [3:0]  leaf;
    logic [47:0] data;
  } bdPacket;

  // filtered spike or tag event from the FPGA
  // 27 state bits match the DSP accumulator width
  typedef struct packed {
    logic [20:0] filtIdx;
    logic [26:0] state;
  } spikeEvent;

  // funnel leaves that exist
  localparam int unsigned BD_LEAF_COUNT = 13;

  // bit n set: leaf n needs two chunks
  // leaves 8..12 carry 48 bits, the rest fit in one chunk
  localparam logic [15:0] BD_TWO_CHUNK_MASK = 16'b0001_1111_0000_0000;

  // heartbeat timing
  localparam int unsigned HEARTBEAT_PERIOD = 64;
  localparam int unsigned TIME_WIDTH = 48;

endpackage

`default_nettype wire

//--- hdl/heartbeatTimer.sv
`timescale 1ns/100ps
`default_nettype none

module heartbeatTimer (
  input  logic                            clk,
  input  logic                            arstN,
  input  logic                            hbTaken,
  output logic                            hbRequest,
  output logic [eventPkg::TIME_WIDTH-1:0] hbTime
);

  // free-running time base
  logic [eventPkg::TIME_WIDTH-1:0] timeCount;
  // position inside the current period, 0 marks a boundary
  logic [$clog2(eventPkg::HEARTBEAT_PERIOD)-1:0] phase;
  logic atBoundary;

  assign atBoundary = (phase == '0);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      timeCount <= '0;
      phase     <= '0;
      hbRequest <= 1'b0;
    end else begin
      timeCount <= timeCount + 1'b1;
      // explicit wrap so the period need not be a power of two
      if (phase == eventPkg::HEARTBEAT_PERIOD - 1) begin
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
      // a new boundary wins over a take in the same cycle
      if (atBoundary) begin
        hbRequest <= 1'b1;
      end else if (hbTaken) begin
        hbRequest <= 1'b0;
      end
    end
  end

  // stamp of the latest boundary, an unserved one gets overwritten
  always_ff @(posedge clk) begin
    if (atBoundary) begin
      hbTime <= timeCount;
    end
  end

endmodule

`default_nettype wire

//--- hdl/bdSerializer.sv
`timescale 1ns/100ps
`default_nettype none

module bdSerializer (
  input  logic                clk,
  input  logic                arstN,
  input  eventPkg::bdPacket   bdIn,
  input  logic                bdValid,
  output logic                bdReady,
  output pcWordPkg::pcStream  bdWords,
  input  logic                bdWordsReady
);

  // held packet
  eventPkg::bdPacket pkt;
  // control state
  logic busy;
  logic chunkIdx;
  logic twoChunk;
  logic accept;
  logic lastTaken;

  // a packet is taken only while idle
  assign bdReady = !busy;
  assign accept = bdValid && !busy;
  // final chunk leaves this cycle
  assign lastTaken = busy && bdWordsReady && (chunkIdx || !twoChunk);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy     <= 1'b0;
      chunkIdx <= 1'b0;
      twoChunk <= 1'b0;
    end else if (accept) begin
      busy     <= 1'b1;
      chunkIdx <= 1'b0;
      // chunk count comes from the leaf table and unknown leaves send one
      twoChunk <= eventPkg::BD_TWO_CHUNK_MASK[bdIn.leaf]
                  && (bdIn.leaf < eventPkg::BD_LEAF_COUNT);
    end else if (lastTaken) begin
      busy     <= 1'b0;
      chunkIdx <= 1'b0;
    end else if (busy && bdWordsReady) begin
      // low chunk is gone and the high one follows
      chunkIdx <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pkt <= bdIn;
    end
  end

  ////////////////////////////////////////////////
  // output word
  ////////////////////////////////////////////////

  // code is the zero-extended leaf and the low chunk goes first
  always_comb begin
    bdWords.valid = busy;
    bdWords.word.code = {{(pcWordPkg::CODE_WIDTH - $bits(pkt.leaf)){1'b0}}, pkt.leaf};
    if (chunkIdx) begin
      bdWords.word.payload.raw = pkt.data[2*pcWordPkg::PAYLOAD_WIDTH-1:pcWordPkg::PAYLOAD_WIDTH];
    end else begin
      bdWords.word.payload.raw = pkt.data[pcWordPkg::PAYLOAD_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

//--- hdl/fpgaSerializer.sv
`timescale 1ns/100ps
`default_nettype none

module fpgaSerializer (
  input  logic                            clk,
  input  logic                            arstN,
  input  eventPkg::spikeEvent             spikeIn,
  input  logic                            spikeValid,
  output logic                            spikeReady,
  input  logic                            hbRequest,
  input  logic [eventPkg::TIME_WIDTH-1:0] hbTime,
  output logic                            hbTaken,
  output pcWordPkg::pcStream              fpgaWords,
  input  logic                            fpgaWordsReady
);

  enum logic [1:0] {IDLE, FIRST, SECOND} state;

  // kind of the pair in flight
  logic hbPair;
  // both halves are captured at the start of a pair
  pcWordPkg::pcPayload loReg;
  pcWordPkg::pcPayload hiReg;
  pcWordPkg::pcPayload loNext;
  pcWordPkg::pcPayload hiNext;
  logic idle;
  logic spikeTake;

  assign idle = (state == IDLE);

  // pending heartbeat beats a waiting spike
  assign hbTaken = idle && hbRequest;
  assign spikeReady = idle && !hbRequest;
  assign spikeTake = spikeReady && spikeValid;

  ////////////////////////////////////////////////
  // payload build
  ////////////////////////////////////////////////

  always_comb begin
    loNext = '0;
    hiNext = '0;
    if (hbRequest) begin
      // time stamp goes out low half first
      loNext.raw = hbTime[pcWordPkg::PAYLOAD_WIDTH-1:0];
      hiNext.raw = hbTime[2*pcWordPkg::PAYLOAD_WIDTH-1:pcWordPkg::PAYLOAD_WIDTH];
    end else begin
      // spike sends the low state bits and then the index with the top state bits
      loNext.raw = spikeIn.state[pcWordPkg::PAYLOAD_WIDTH-1:0];
      hiNext.hi.filtIdx = spikeIn.filtIdx;
      hiNext.hi.stateHi = spikeIn.state[26:pcWordPkg::PAYLOAD_WIDTH];
    end
  end

  always_ff @(posedge clk) begin
    if (hbTaken || spikeTake) begin
      hbPair <= hbRequest;
      loReg  <= loNext;
      hiReg  <= hiNext;
    end
  end

  // state advances idle to first to second on each taken word
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (hbTaken || spikeTake) begin
            state <= FIRST;
          end
        end
        FIRST: begin
          if (fpgaWordsReady) begin
            state <= SECOND;
          end
        end
        SECOND: begin
          if (fpgaWordsReady) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    fpgaWords.valid = !idle;
    fpgaWords.word.code = hbPair ? pcWordPkg::CODE_HEARTBEAT : pcWordPkg::CODE_SPIKE;
    fpgaWords.word.payload = (state == SECOND) ? hiReg : loReg;
  end

endmodule

`default_nettype wire

//--- hdl/channelMerge.sv
`timescale 1ns/100ps
`default_nettype none

module channelMerge (
  input  logic               clk,
  input  logic               arstN,
  input  pcWordPkg::pcStream inA,
  output logic               readyA,
  input  pcWordPkg::pcStream inB,
  output logic               readyB,
  output pcWordPkg::pcStream out,
  input  logic               outReady
);

  // output stage
  logic            outValid;
  pcWordPkg::pcWord outWord;
  // 0 favours A, 1 favours B
  logic rrPtr;
  logic load;
  logic grantA;
  logic grantB;

  // register free now or emptied this cycle
  assign load = !outValid || outReady;

  ////////////////////////////////////////////////
  // round-robin arbitration
  ////////////////////////////////////////////////

  // a lone valid input always wins, ties go by the pointer
  assign grantA = inA.valid && (!inB.valid || !rrPtr);
  assign grantB = inB.valid && (!inA.valid || rrPtr);

  // loser sees ready low and holds its beat
  assign readyA = load && grantA;
  assign readyB = load && grantB;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
      rrPtr    <= 1'b0;
    end else if (load) begin
      outValid <= grantA || grantB;
      // point away from whoever was just served
      if (grantA || grantB) begin
        rrPtr <= grantA;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      outWord <= grantA ? inA.word : inB.word;
    end
  end

  assign out.valid = outValid;
  assign out.word = outWord;

endmodule

`default_nettype wire

//--- hdl/pcPacker.sv
`timescale 1ns/100ps
`default_nettype none

module pcPacker (
  input  logic               clk,
  input  logic               arstN,
  input  pcWordPkg::pcStream bdWords,
  output logic               bdWordsReady,
  input  pcWordPkg::pcStream fpgaWords,
  output logic               fpgaWordsReady,
  output pcWordPkg::pcStream pcOut,
  input  logic               pcReady
);

  // packed streams into the merge
  pcWordPkg::pcStream bdPacked;
  pcWordPkg::pcStream fpgaPacked;

  ////////////////////////////////////////////////
  // code over payload, per source
  ////////////////////////////////////////////////

  // code ranges do not overlap, so no source bit is added
  assign bdPacked.valid = bdWords.valid;
  assign bdPacked.word = {bdWords.word.code, bdWords.word.payload};

  assign fpgaPacked.valid = fpgaWords.valid;
  assign fpgaPacked.word = {fpgaWords.word.code, fpgaWords.word.payload};

  // BD on A, FPGA on B
  channelMerge u_merge (
    .clk      (clk),
    .arstN    (arstN),
    .inA      (bdPacked),
    .readyA   (bdWordsReady),
    .inB      (fpgaPacked),
    .readyB   (fpgaWordsReady),
    .out      (pcOut),
    .outReady (pcReady)
  );

endmodule

`default_nettype wire

//--- hdl/pcUplink.sv
`timescale 1ns/100ps
`default_nettype none

module pcUplink (
  input  logic                clk,
  input  logic                arstN,
  input  eventPkg::bdPacket   bdIn,
  input  logic                bdValid,
  output logic                bdReady,
  input  eventPkg::spikeEvent spikeIn,
  input  logic                spikeValid,
  output logic                spikeReady,
  output pcWordPkg::pcStream  pcOut,
  input  logic                pcReady
);

  // heartbeat handshake
  logic hbRequest;
  logic hbTaken;
  logic [eventPkg::TIME_WIDTH-1:0] hbTime;

  // serialized streams into the packer
  pcWordPkg::pcStream bdWords;
  logic bdWordsReady;
  pcWordPkg::pcStream fpgaWords;
  logic fpgaWordsReady;

  heartbeatTimer u_timer (
    .clk       (clk),
    .arstN     (arstN),
    .hbTaken   (hbTaken),
    .hbRequest (hbRequest),
    .hbTime    (hbTime)
  );

  bdSerializer u_bdSer (
    .clk          (clk),
    .arstN        (arstN),
    .bdIn         (bdIn),
    .bdValid      (bdValid),
    .bdReady      (bdReady),
    .bdWords      (bdWords),
    .bdWordsReady (bdWordsReady)
  );

  fpgaSerializer u_fpgaSer (
    .clk            (clk),
    .arstN          (arstN),
    .spikeIn        (spikeIn),
    .spikeValid     (spikeValid),
    .spikeReady     (spikeReady),
    .hbRequest      (hbRequest),
    .hbTime         (hbTime),
    .hbTaken        (hbTaken),
    .fpgaWords      (fpgaWords),
    .fpgaWordsReady (fpgaWordsReady)
  );

  pcPacker u_packer (
    .clk            (clk),
    .arstN          (arstN),
    .bdWords        (bdWords),
    .bdWordsReady   (bdWordsReady),
    .fpgaWords      (fpgaWords),
    .fpgaWordsReady (fpgaWordsReady),
    .pcOut          (pcOut),
    .pcReady        (pcReady)
  );

endmodule

`default_nettype wire

//--- bench/pcUplinkTb.sv
`timescale 1ns/100ps
`default_nettype none

module pcUplinkTb;

  // five tests need about 2500 cycles plus margin
  localparam int unsigned TIMEOUT_CYCLES = 4000;
  localparam int unsigned BURST_COUNT = 100;

  logic                clk;
  logic                arstN;
  eventPkg::bdPacket   bdIn;
  logic                bdValid;
  logic                bdReady;
  eventPkg::spikeEvent spikeIn;
  logic                spikeValid;
  logic                spikeReady;
  pcWordPkg::pcStream  pcOut;
  logic                pcReady;

  // one queue of expected words per source
  pcWordPkg::pcWord bdQ[$];
  pcWordPkg::pcWord spikeQ[$];
  pcWordPkg::pcWord hbQ[$];

  logic [31:0]      rngState = 32'hef08;
  int unsigned      checkErrors = 0;
  int unsigned      wordCount = 0;
  int unsigned      hbWordCount = 0;
  int unsigned      cycleCount = 0;
  logic             stallOn = 1'b0;
  logic [47:0]      hbClock;
  // output hold tracking and FPGA pair tracking
  logic             stallSeen = 1'b0;
  pcWordPkg::pcWord heldWord;
  logic             pairOpen = 1'b0;
  logic [7:0]       pairCode = '0;

  pcUplink u_dut (
    .clk        (clk),
    .arstN      (arstN),
    .bdIn       (bdIn),
    .bdValid    (bdValid),
    .bdReady    (bdReady),
    .spikeIn    (spikeIn),
    .spikeValid (spikeValid),
    .spikeReady (spikeReady),
    .pcOut      (pcOut),
    .pcReady    (pcReady)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // random 48-bit packet on the given leaf
  task automatic sendBd(input logic [3:0] leaf);
    eventPkg::bdPacket p;
    pcWordPkg::pcWord  w;
    logic [31:0]       r1;
    logic [31:0]       r2;
    r1 = xorshift();
    r2 = xorshift();
    p.leaf = leaf;
    p.data = {r1[15:0], r2};
    // low chunk always and high chunk only on leaves 8..12
    w.code = {4'd0, leaf};
    w.payload.raw = p.data[23:0];
    bdQ.push_back(w);
    if (leaf >= 4'd8 && leaf <= 4'd12) begin
      w.payload.raw = p.data[47:24];
      bdQ.push_back(w);
    end
    @(negedge clk);
    bdIn = p;
    bdValid = 1'b1;
    // ready is read before the edge updates it
    @(posedge clk);
    while (!bdReady) @(posedge clk);
    @(negedge clk);
    bdValid = 1'b0;
  endtask

  task automatic sendSpike();
    eventPkg::spikeEvent e;
    pcWordPkg::pcWord    w;
    logic [31:0]         r1;
    logic [31:0]         r2;
    r1 = xorshift();
    r2 = xorshift();
    e.filtIdx = r1[20:0];
    e.state = r2[26:0];
    // state low bits and then index with state top bits
    w.code = 8'd14;
    w.payload.raw = e.state[23:0];
    spikeQ.push_back(w);
    w.payload.hi.filtIdx = e.filtIdx;
    w.payload.hi.stateHi = e.state[26:24];
    spikeQ.push_back(w);
    @(negedge clk);
    spikeIn = e;
    spikeValid = 1'b1;
    @(posedge clk);
    while (!spikeReady) @(posedge clk);
    @(negedge clk);
    spikeValid = 1'b0;
  endtask

  task automatic waitDrain();
    while (bdQ.size() != 0 || spikeQ.size() != 0) @(negedge clk);
  endtask

  task automatic reportTest(input int num, input string name,
                            input int unsigned errs, input int unsigned words);
    $display("test %0d %s: %0d words checked, %0d errors", num, name, words, errs);
  endtask

  // random stalls on roughly one cycle in four
  always @(negedge clk) begin
    if (stallOn) begin
      pcReady = (xorshift() % 32'd4) != 32'd0;
    end else begin
      pcReady = 1'b1;
    end
  end

  // heartbeat model emits a stamp every period from time zero
  always @(posedge clk or negedge arstN) begin : heartbeatModel
    pcWordPkg::pcWord w;
    if (!arstN) begin
      hbClock = '0;
    end else begin
      if (hbClock % eventPkg::HEARTBEAT_PERIOD == 0) begin
        w.code = 8'd15;
        w.payload.raw = hbClock[23:0];
        hbQ.push_back(w);
        w.payload.raw = hbClock[47:24];
        hbQ.push_back(w);
      end
      hbClock = hbClock + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // output checks
  //////////////////////////////////////////////////

  // pcOut is registered so values read here are the pre-edge ones
  always @(posedge clk) begin : outputCheck
    pcWordPkg::pcWord got;
    pcWordPkg::pcWord exp;
    logic             haveExp;
    logic             isFpga;
    if (arstN) begin
      if (stallSeen) begin
        assert (pcOut.valid && pcOut.word == heldWord) else begin
          checkErrors++;
          $display("CHECK FAILED pcOut got %h expected %h", pcOut, {1'b1, heldWord});
        end
      end
      stallSeen = pcOut.valid && !pcReady;
      heldWord = pcOut.word;
      if (pcOut.valid && pcReady) begin
        got = pcOut.word;
        exp = '0;
        haveExp = 1'b0;
        wordCount++;
        isFpga = (got.code == 8'd14) || (got.code == 8'd15);
        // an FPGA pair is never split by another FPGA word
        if (isFpga && pairOpen) begin
          assert (got.code == pairCode) else begin
            checkErrors++;
            $display("FPGA pair with code %0d split by a word with code %0d",
                     pairCode, got.code);
          end
        end
        if (isFpga) begin
          pairOpen = !pairOpen;
          pairCode = got.code;
        end
        // code selects the reference queue
        if (got.code <= 8'd12 && bdQ.size() != 0) begin
          exp = bdQ.pop_front();
          haveExp = 1'b1;
        end else if (got.code == 8'd14 && spikeQ.size() != 0) begin
          exp = spikeQ.pop_front();
          haveExp = 1'b1;
        end else if (got.code == 8'd15 && hbQ.size() != 0) begin
          exp = hbQ.pop_front();
          haveExp = 1'b1;
          hbWordCount++;
        end
        assert (haveExp) else begin
          checkErrors++;
          $display("word %h with code %0d arrived while no such word was expected",
                   got, got.code);
        end
        if (haveExp) begin
          assert (got == exp) else begin
            checkErrors++;
            $display("CHECK FAILED pcOut.word got %h expected %h", got, exp);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles with words still pending", cycleCount);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : mainSequence
    int unsigned seqErrors;
    int unsigned errBefore;
    int unsigned wordBefore;
    int unsigned hbBefore;
    logic [31:0] leafRand;
    int          i;
    seqErrors = 0;
    bdIn = '0;
    bdValid = 1'b0;
    spikeIn = '0;
    spikeValid = 1'b0;
    pcReady = 1'b1;
    arstN = 1'b0;
    repeat (5) @(negedge clk);
    arstN = 1'b1;

    // leaves 0..7 carry one chunk each
    errBefore = checkErrors;
    wordBefore = wordCount;
    for (i = 0; i < 8; i++) begin
      sendBd(i[3:0]);
    end
    waitDrain();
    reportTest(1, "one-chunk BD", checkErrors - errBefore, wordCount - wordBefore);

    // leaves 8..12 carry two chunks each
    errBefore = checkErrors;
    wordBefore = wordCount;
    for (i = 8; i <= 12; i++) begin
      sendBd(i[3:0]);
    end
    waitDrain();
    reportTest(2, "two-chunk BD", checkErrors - errBefore, wordCount - wordBefore);

    errBefore = checkErrors;
    wordBefore = wordCount;
    repeat (30) sendSpike();
    waitDrain();
    reportTest(3, "spike events", checkErrors - errBefore, wordCount - wordBefore);

    // with idle inputs only the timer talks
    // any 264-cycle window holds 4 full pairs
    errBefore = checkErrors + seqErrors;
    wordBefore = wordCount;
    hbBefore = hbWordCount;
    repeat (4 * eventPkg::HEARTBEAT_PERIOD + 8) @(negedge clk);
    assert (hbWordCount - hbBefore >= 8) else begin
      seqErrors++;
      $display("only %0d heartbeat words arrived in four periods", hbWordCount - hbBefore);
    end
    reportTest(4, "heartbeats", checkErrors + seqErrors - errBefore, wordCount - wordBefore);

    // both sources busy under random stalls
    errBefore = checkErrors;
    wordBefore = wordCount;
    stallOn = 1'b1;
    fork
      begin
        repeat (BURST_COUNT) begin
          leafRand = xorshift() % 32'd13;
          sendBd(leafRand[3:0]);
        end
      end
      begin
        repeat (BURST_COUNT) sendSpike();
      end
    join
    waitDrain();
    stallOn = 1'b0;
    reportTest(5, "back-pressure and merge", checkErrors - errBefore,
               wordCount - wordBefore);

    // every queue must end empty including heartbeats
    while (hbQ.size() != 0) @(negedge clk);
    $display("5 tests, %0d words checked, %0d heartbeat words, %0d errors",
             wordCount, hbWordCount, checkErrors + seqErrors);
    if (checkErrors + seqErrors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- pcUplink.f
hdl/pcWordPkg.sv
hdl/eventPkg.sv
hdl/heartbeatTimer.sv
hdl/bdSerializer.sv
hdl/fpgaSerializer.sv
hdl/channelMerge.sv
hdl/pcPacker.sv
hdl/pcUplink.sv
bench/pcUplinkTb.sv

//--- Bender.yml
package:
  name: pcUplink

sources:
  - hdl/pcWordPkg.sv
  - hdl/eventPkg.sv
  - hdl/heartbeatTimer.sv
  - hdl/bdSerializer.sv
  - hdl/fpgaSerializer.sv
  - hdl/channelMerge.sv
  - hdl/pcPacker.sv
  - hdl/pcUplink.sv
  - target: test
    files:
      - bench/pcUplinkTb.sv
